// ==== include/soc_config.svh ====
// soc configuration macros: memory map, memory depths, wait states and bus widths
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// **************************************************
// bus widths
// **************************************************
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// **************************************************
// memory map
// **************************************************
// top four address bits pick the region
`define SOC_REGION_SHIFT 28
// 0x0xxx_xxxx, slave 1
`define SOC_SMEM_REGION 4'h0
// 0x2xxx_xxxx, slave 5
`define SOC_DMEM_REGION 4'h2

// depths in words, powers of two
`define SOC_SMEM_WORDS 256
`define SOC_DMEM_WORDS 512

// wait states ahead of each transfer
`define SOC_AHB_DELAY_CYCLES 1

`endif

// ==== project.f ====
+incdir+include
source/soc_pkg.sv
source/ahb_if.sv
source/ahb_delay.sv
source/ahb_decoder.sv
source/mem_ctrl.sv
source/err_gen.sv
source/soc.sv
testbench/tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the soc testbench with verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_soc \
  -f project.f --Mdir obj_dir -o tb_soc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
exit 0

// ==== source/ahb_decoder.sv ====
// ahb decoder: region select toward the slaves and response mux back to the master
`default_nettype none

`include "soc_config.svh"

module ahb_decoder import soc_pkg::*; (
  input  wire logic    i_pad_clk,
  input  wire logic    i_arst_n,
  ahb_bus_if.target    up,
  ahb_slave_if.manager smem,
  ahb_slave_if.manager dmem,
  ahb_slave_if.manager errs
);

  logic [3:0] region;
  slave_sel_e asel;
  slave_sel_e dsel_q;
  logic       active;

  // **************************************************
  // address phase decode
  // **************************************************
  assign region = 4'(up.haddr >> `SOC_REGION_SHIFT);
  assign active = (up.htrans == NONSEQ) || (up.htrans == SEQ);

  always_comb begin
    case (region)
      `SOC_SMEM_REGION: asel = SEL_SMEM;
      `SOC_DMEM_REGION: asel = SEL_DMEM;
      // everything else lands on the default slave
      default:          asel = SEL_ERR;
    endcase
  end

  assign smem.hsel = (asel == SEL_SMEM);
  assign dmem.hsel = (asel == SEL_DMEM);
  assign errs.hsel = (asel == SEL_ERR);

  // request fan out, identical for all three
  assign smem.haddr  = up.haddr;
  assign smem.htrans = up.htrans;
  assign smem.hwrite = up.hwrite;
  assign smem.hsize  = up.hsize;
  assign smem.hwdata = up.hwdata;
  assign dmem.haddr  = up.haddr;
  assign dmem.htrans = up.htrans;
  assign dmem.hwrite = up.hwrite;
  assign dmem.hsize  = up.hsize;
  assign dmem.hwdata = up.hwdata;
  assign errs.haddr  = up.haddr;
  assign errs.htrans = up.htrans;
  assign errs.hwrite = up.hwrite;
  assign errs.hsize  = up.hsize;
  assign errs.hwdata = up.hwdata;

  // data phase slave's hready, seen by everyone
  assign smem.hready_in = up.hready;
  assign dmem.hready_in = up.hready;
  assign errs.hready_in = up.hready;

  // **************************************************
  // data phase select and response mux
  // **************************************************
  always_ff @(posedge i_pad_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dsel_q <= SEL_SMEM;
    end else if (up.hready && active) begin
      dsel_q <= asel;
    end
  end

  always_comb begin
    case (dsel_q)
      SEL_DMEM: begin
        up.hrdata = dmem.hrdata;
        up.hready = dmem.hready;
        up.hresp  = dmem.hresp;
      end
      SEL_ERR: begin
        up.hrdata = errs.hrdata;
        up.hready = errs.hready;
        up.hresp  = errs.hresp;
      end
      default: begin
        up.hrdata = smem.hrdata;
        up.hready = smem.hready;
        up.hresp  = smem.hresp;
      end
    endcase
  end

  // only the data phase slave may stall the bus
  a_idle_slaves_ready: assert property (
    @(posedge i_pad_clk) disable iff (!i_arst_n)
    (dsel_q == SEL_SMEM || smem.hready) &&
    (dsel_q == SEL_DMEM || dmem.hready) &&
    (dsel_q == SEL_ERR  || errs.hready)
  );

endmodule

`default_nettype wire

// ==== source/ahb_delay.sv ====
// ahb delay stage: holds each master address phase for a fixed wait count, then forwards it
`default_nettype none

`include "soc_config.svh"

module ahb_delay import soc_pkg::*; (
  input  wire logic     i_pad_clk,
  input  wire logic     i_arst_n,
  input  wire addr_t    i_haddr,
  input  wire htrans_e  i_htrans,
  input  wire logic     i_hwrite,
  input  wire hsize_e   i_hsize,
  input  wire data_t    i_hwdata,
  output data_t         o_hrdata,
  output logic          o_hready,
  output hresp_e        o_hresp,
  ahb_bus_if.initiator  bus
);

  localparam int D = `SOC_AHB_DELAY_CYCLES;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ADDR, ST_DATA} dly_state_e;

  dly_state_e state_q;
  dly_state_e state_d;
  dly_state_e first_st;
  logic [7:0] wait_cnt_q;
  logic [7:0] lo_run_q;
  logic       accept;
  addr_t      hold_addr_q;
  htrans_e    hold_htrans_q;
  logic       hold_hwrite_q;
  hsize_e     hold_hsize_q;

  // **************************************************
  // master side acceptance
  // **************************************************
  assign accept   = o_hready && (i_htrans == NONSEQ || i_htrans == SEQ);
  // zero wait count skips straight to the address cycle
  assign first_st = (D == 0) ? ST_ADDR : ST_WAIT;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) state_d = first_st;
      end
      ST_WAIT: begin
        if (wait_cnt_q == 8'(D - 1)) state_d = ST_ADDR;
      end
      ST_ADDR: begin
        // address phase completes only with hready high
        if (bus.hready) state_d = ST_DATA;
      end
      default: begin
        // back to back when master has the next one waiting
        if (bus.hready) state_d = accept ? first_st : ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_pad_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= ST_IDLE;
      wait_cnt_q <= '0;
      lo_run_q   <= '0;
    end else begin
      state_q    <= state_d;
      wait_cnt_q <= (state_q == ST_WAIT) ? wait_cnt_q + 8'd1 : '0;
      lo_run_q   <= o_hready ? '0 : lo_run_q + 8'd1;
    end
  end

  // captured address phase
  always_ff @(posedge i_pad_clk) begin
    if (accept) begin
      hold_addr_q   <= i_haddr;
      hold_htrans_q <= i_htrans;
      hold_hwrite_q <= i_hwrite;
      hold_hsize_q  <= i_hsize;
    end
  end

  // **************************************************
  // downstream request and master response
  // **************************************************
  assign bus.haddr  = hold_addr_q;
  assign bus.htrans = (state_q == ST_ADDR) ? hold_htrans_q : IDLE;
  assign bus.hwrite = hold_hwrite_q;
  assign bus.hsize  = hold_hsize_q;
  // master keeps hwdata stable through the whole stall
  assign bus.hwdata = i_hwdata;

  assign o_hrdata = bus.hrdata;
  assign o_hresp  = (state_q == ST_DATA) ? bus.hresp : OKAY;
  assign o_hready = (state_q == ST_IDLE) ||
                    ((state_q == ST_DATA) && bus.hready);

  // worst case is the error response, D+2 low cycles
  a_stall_bound: assert property (
    @(posedge i_pad_clk) disable iff (!i_arst_n)
    lo_run_q <= 8'(D + 3)
  );

endmodule

`default_nettype wire

// ==== source/ahb_if.sv ====
// AHB-Lite interfaces for the delay-to-decoder link and the decoder-to-slave links
`default_nettype none

// single master to decoder
interface ahb_bus_if import soc_pkg::*; ();
  addr_t   haddr;
  htrans_e htrans;
  logic    hwrite;
  hsize_e  hsize;
  data_t   hwdata;
  data_t   hrdata;
  logic    hready;
  hresp_e  hresp;

  // request side
  modport initiator (
    output haddr, htrans, hwrite, hsize, hwdata,
    input  hrdata, hready, hresp
  );

  // response side
  modport target (
    input  haddr, htrans, hwrite, hsize, hwdata,
    output hrdata, hready, hresp
  );
endinterface

// decoder to one slave
interface ahb_slave_if import soc_pkg::*; ();
  addr_t   haddr;
  htrans_e htrans;
  logic    hwrite;
  hsize_e  hsize;
  data_t   hwdata;
  logic    hsel;
  // muxed hready, end of current data phase
  logic    hready_in;
  data_t   hrdata;
  logic    hready;
  hresp_e  hresp;

  modport manager (
    output haddr, htrans, hwrite, hsize, hwdata, hsel, hready_in,
    input  hrdata, hready, hresp
  );

  modport slave (
    input  haddr, htrans, hwrite, hsize, hwdata, hsel, hready_in,
    output hrdata, hready, hresp
  );
endinterface

`default_nettype wire

// ==== source/err_gen.sv ====
// default slave: answers any transfer to an unmapped region with a two-cycle ERROR
`default_nettype none

module err_gen import soc_pkg::*; (
  input  wire logic  i_pad_clk,
  input  wire logic  i_arst_n,
  ahb_slave_if.slave bus
);

  logic accept;
  // first and second data phase cycle
  logic err_1st_q;
  logic err_2nd_q;

  // **************************************************
  // transfer detect
  // **************************************************
  assign accept = bus.hsel && bus.hready_in &&
                  (bus.htrans == NONSEQ || bus.htrans == SEQ);

  always_ff @(posedge i_pad_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      err_1st_q <= 1'b0;
      err_2nd_q <= 1'b0;
    end else begin
      // hready_in is low during the first cycle, so no overlap
      err_1st_q <= accept;
      err_2nd_q <= err_1st_q;
    end
  end

  // **************************************************
  // response
  // **************************************************
  // low then high, error in both
  assign bus.hready = !err_1st_q;
  assign bus.hresp  = (err_1st_q || err_2nd_q) ? ERROR : OKAY;
  // nothing to read here
  assign bus.hrdata = '0;

  // no new transfer lands on the first error cycle
  a_err_no_overlap: assert property (
    @(posedge i_pad_clk) disable iff (!i_arst_n)
    accept |-> !err_1st_q
  );

endmodule

`default_nettype wire

// ==== source/mem_ctrl.sv ====
// sram slave: zero wait AHB-Lite memory with little-endian byte lane writes
`default_nettype none

`include "soc_config.svh"

module mem_ctrl import soc_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  wire logic  i_pad_clk,
  input  wire logic  i_arst_n,
  ahb_slave_if.slave bus
);

  // depth assumed a power of two, offsets past it alias
  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int LANES = `SOC_DATA_W / 8;

  data_t              mem [MEM_WORDS];
  logic [IDX_W-1:0]   idx_q;
  logic [LANES-1:0]   lane_d;
  logic [LANES-1:0]   lane_q;
  logic               wr_pend_q;
  logic               accept;

  // **************************************************
  // address phase
  // **************************************************
  assign accept = bus.hsel && bus.hready_in &&
                  (bus.htrans == NONSEQ || bus.htrans == SEQ);

  // lane 0 is the low byte
  always_comb begin
    case (bus.hsize)
      BYTE:    lane_d = LANES'(1) << bus.haddr[1:0];
      HALF:    lane_d = LANES'(3) << {bus.haddr[1], 1'b0};
      default: lane_d = '1;
    endcase
  end

  // word index and lanes of the transfer
  always_ff @(posedge i_pad_clk) begin
    if (accept) begin
      idx_q  <= bus.haddr[IDX_W+1:2];
      lane_q <= lane_d;
    end
  end

  // write pending for the data phase
  always_ff @(posedge i_pad_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_pend_q <= 1'b0;
    end else if (bus.hready_in) begin
      wr_pend_q <= accept && bus.hwrite;
    end
  end

  // **************************************************
  // data phase
  // **************************************************
  // hwdata lands on the edge that closes the data phase
  always_ff @(posedge i_pad_clk) begin
    if (wr_pend_q && bus.hready_in) begin
      for (int b = 0; b < LANES; b++) begin
        if (lane_q[b]) mem[idx_q][8*b +: 8] <= bus.hwdata[8*b +: 8];
      end
    end
  end

  // full word back, master picks its lanes
  assign bus.hrdata = mem[idx_q];
  assign bus.hready = 1'b1;
  assign bus.hresp  = OKAY;

  // sizes above a word and unaligned addresses are not handled
  a_size_align: assert property (
    @(posedge i_pad_clk) disable iff (!i_arst_n)
    accept |-> (bus.hsize <= WORD) &&
               ((bus.hsize != HALF) || !bus.haddr[0]) &&
               ((bus.hsize != WORD) || (bus.haddr[1:0] == 2'b00))
  );

endmodule

`default_nettype wire

// ==== source/soc.sv ====
// soc top: delay stage, decoder, two sram slaves and the error slave behind one AHB-Lite master
`default_nettype none

`include "soc_config.svh"

module soc import soc_pkg::*; (
  input  wire logic    i_pad_clk,
  input  wire logic    i_arst_n,
  input  wire addr_t   i_haddr,
  input  wire htrans_e i_htrans,
  input  wire logic    i_hwrite,
  input  wire hsize_e  i_hsize,
  input  wire data_t   i_hwdata,
  output data_t        o_hrdata,
  output logic         o_hready,
  output hresp_e       o_hresp
);

  // delay to decoder
  ahb_bus_if   u_bus ();
  // decoder to each slave
  ahb_slave_if u_smem_bus ();
  ahb_slave_if u_dmem_bus ();
  ahb_slave_if u_err_bus ();

  // **************************************************
  // wait state insertion
  // **************************************************
  ahb_delay u_ahb_delay (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .i_haddr   (i_haddr),
    .i_htrans  (i_htrans),
    .i_hwrite  (i_hwrite),
    .i_hsize   (i_hsize),
    .i_hwdata  (i_hwdata),
    .o_hrdata  (o_hrdata),
    .o_hready  (o_hready),
    .o_hresp   (o_hresp),
    .bus       (u_bus.initiator)
  );

  // **************************************************
  // address decode
  // **************************************************
  ahb_decoder u_ahb_decoder (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .up        (u_bus.target),
    .smem      (u_smem_bus.manager),
    .dmem      (u_dmem_bus.manager),
    .errs      (u_err_bus.manager)
  );

  // **************************************************
  // slaves
  // **************************************************
  // slave 1
  mem_ctrl #(.MEM_WORDS(`SOC_SMEM_WORDS)) u_smem_ctrl (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .bus       (u_smem_bus.slave)
  );

  // slave 3, unmapped regions
  err_gen u_err_gen (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .bus       (u_err_bus.slave)
  );

  // slave 5
  mem_ctrl #(.MEM_WORDS(`SOC_DMEM_WORDS)) u_dmem_ctrl (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .bus       (u_dmem_bus.slave)
  );

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
// soc package with the AHB-Lite bus types and the decoder slave select
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

  // **************************************************
  // bus payload
  // **************************************************
  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;

  // **************************************************
  // AHB-Lite encodings
  // **************************************************
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // no kept slave takes more than a word
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // only okay and error ever show up
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // decoder target
  typedef enum logic [1:0] {
    SEL_SMEM,
    SEL_DMEM,
    SEL_ERR
  } slave_sel_e;

endpackage

`default_nettype wire

// ==== testbench/soc_stim.txt ====
# op addr size wdata exp_rdata exp_resp, all fields after op in hex
# op W write, R read, I idle; size 0 byte, 1 half, 2 word; resp 0 okay, 1 error
I 00000000 0 00000000 00000000 0
# word writes and reads, same offset in both regions
W 00000010 2 11223344 00000000 0
W 20000010 2 aabbccdd 00000000 0
R 00000010 2 00000000 11223344 0
R 20000010 2 00000000 aabbccdd 0
W 00000020 2 01020304 00000000 0
W 20000024 2 deadbeef 00000000 0
R 00000020 2 00000000 01020304 0
R 20000024 2 00000000 deadbeef 0
# byte and halfword lanes merge into the word
W 00000040 2 00000000 00000000 0
W 00000041 0 0000ab00 00000000 0
W 00000043 0 cd000000 00000000 0
R 00000040 2 00000000 cd00ab00 0
W 20000080 2 ffffffff 00000000 0
W 20000082 1 12340000 00000000 0
W 20000080 0 0000005a 00000000 0
R 20000080 2 00000000 1234ff5a 0
W 20000080 1 0000beef 00000000 0
R 20000080 2 00000000 1234beef 0
# offsets past the depth alias
W 00000404 2 cafef00d 00000000 0
R 00000004 2 00000000 cafef00d 0
R 00000410 2 00000000 11223344 0
W 20000808 2 feedface 00000000 0
R 20000008 2 00000000 feedface 0
W 20000004 2 13579bdf 00000000 0
W 20000404 2 2468ace0 00000000 0
R 20000004 2 00000000 13579bdf 0
R 20000c04 2 00000000 2468ace0 0
# unmapped regions answer with error
W 10000010 2 99999999 00000000 1
R 30000000 2 00000000 00000000 1
W f0000020 2 77777777 00000000 1
I 00000000 0 00000000 00000000 0
# mapped words unchanged after the error accesses
R 00000010 2 00000000 11223344 0
R 20000010 2 00000000 aabbccdd 0
R 00000020 2 00000000 01020304 0
I 00000000 0 00000000 00000000 0

// ==== testbench/tb_soc.sv ====
// soc testbench: replays AHB-Lite transfers from the stimulus file and checks each response
`default_nettype none

`include "soc_config.svh"

module tb_soc import soc_pkg::*; ();

  localparam int D       = `SOC_AHB_DELAY_CYCLES;
  // cycles any single wait may take
  localparam int TIMEOUT = 32;

  logic    i_pad_clk;
  logic    i_arst_n;
  addr_t   i_haddr;
  htrans_e i_htrans;
  logic    i_hwrite;
  hsize_e  i_hsize;
  data_t   i_hwdata;
  data_t   o_hrdata;
  logic    o_hready;
  hresp_e  o_hresp;

  int   mismatch_cnt;
  int   timeout_cnt;
  int   other_cnt;
  int   xfer_cnt;
  logic timed_out;

  soc u_dut (
    .i_pad_clk (i_pad_clk),
    .i_arst_n  (i_arst_n),
    .i_haddr   (i_haddr),
    .i_htrans  (i_htrans),
    .i_hwrite  (i_hwrite),
    .i_hsize   (i_hsize),
    .i_hwdata  (i_hwdata),
    .o_hrdata  (o_hrdata),
    .o_hready  (o_hready),
    .o_hresp   (o_hresp)
  );

  // 40 unit period
  initial begin
    i_pad_clk = 1'b0;
    forever begin
      #20 i_pad_clk = ~i_pad_clk;
    end
  end

  // **************************************************
  // bus tasks, all on the falling edge
  // **************************************************
  // master may only start while o_hready is high
  task automatic wait_ready(output logic ok);
    int n;
    n = 0;
    while (!o_hready && n < TIMEOUT) begin
      @(negedge i_pad_clk);
      n++;
    end
    ok = o_hready;
  endtask

  // one-cycle idle, bus must sit ready and okay
  task automatic check_idle();
    @(negedge i_pad_clk);
    if (o_hready !== 1'b1) begin
      mismatch_cnt++;
      $display("mismatch o_hready while idle: got %h expected %h", o_hready, 1'b1);
    end
    if (o_hresp !== OKAY) begin
      mismatch_cnt++;
      $display("mismatch o_hresp while idle: got %h expected %h", o_hresp, OKAY);
    end
  endtask

  task automatic run_transfer(input logic wr, input addr_t addr, input logic [2:0] size,
                              input data_t wdata, input data_t exp_rdata,
                              input logic exp_resp);
    int     gap;
    int     n_low;
    int     exp_low;
    logic   ok;
    hresp_e low_resp;
    // 0 to 3 idle cycles ahead
    gap = $urandom % 4;
    repeat (gap) @(negedge i_pad_clk);
    wait_ready(ok);
    if (!ok) begin
      timeout_cnt++;
      timed_out = 1'b1;
      $display("timeout: o_hready stayed low before the transfer to %h", addr);
    end else begin
      // address phase
      i_haddr  = addr;
      i_htrans = NONSEQ;
      i_hwrite = wr;
      i_hsize  = hsize_e'(size);
      @(negedge i_pad_clk);
      // data phase, nothing queued behind it
      i_htrans = IDLE;
      i_hwdata = wdata;
      n_low    = 0;
      low_resp = OKAY;
      while (!o_hready && n_low < TIMEOUT) begin
        low_resp = o_hresp;
        n_low++;
        @(negedge i_pad_clk);
      end
      if (!o_hready) begin
        timeout_cnt++;
        timed_out = 1'b1;
        $display("timeout: transfer to %h never completed", addr);
      end else begin
        // D waits plus the address cycle, one more for the error's first cycle
        exp_low = exp_resp ? D + 2 : D + 1;
        if (n_low != exp_low) begin
          mismatch_cnt++;
          $display("mismatch o_hready low cycles at %h: got %0h expected %0h",
                   addr, n_low, exp_low);
        end
        // last low cycle already carries the error
        if (low_resp !== hresp_e'(exp_resp)) begin
          mismatch_cnt++;
          $display("mismatch o_hresp before completion at %h: got %h expected %h",
                   addr, low_resp, exp_resp);
        end
        if (o_hresp !== hresp_e'(exp_resp)) begin
          mismatch_cnt++;
          $display("mismatch o_hresp at %h: got %h expected %h", addr, o_hresp, exp_resp);
        end
        if (!wr && !exp_resp && o_hrdata !== exp_rdata) begin
          mismatch_cnt++;
          $display("mismatch o_hrdata at %h: got %h expected %h", addr, o_hrdata, exp_rdata);
        end
        // let the completing edge pass
        @(negedge i_pad_clk);
      end
    end
  endtask

  // **************************************************
  // main sequence
  // **************************************************
  initial begin
    int          fd;
    int          n;
    int          c;
    int          err_cnt;
    logic        done;
    logic [7:0]  op;
    addr_t       f_addr;
    logic [31:0] f_size;
    data_t       f_wdata;
    data_t       f_rdata;
    logic [31:0] f_resp;
    void'($urandom(32'h2151_1bda));
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    other_cnt    = 0;
    xfer_cnt     = 0;
    timed_out    = 1'b0;
    i_arst_n     = 1'b0;
    i_haddr      = '0;
    i_htrans     = IDLE;
    i_hwrite     = 1'b0;
    i_hsize      = WORD;
    i_hwdata     = '0;
    repeat (8) @(negedge i_pad_clk);
    i_arst_n = 1'b1;
    // bus ready and okay before anything is issued
    check_idle();

    fd = $fopen("testbench/soc_stim.txt", "r");
    if (fd == 0) begin
      other_cnt++;
      $display("cannot open the stimulus file testbench/soc_stim.txt");
    end else begin
      done = 1'b0;
      while (!done && !timed_out) begin
        n = $fscanf(fd, " %c", op);
        if (n != 1) begin
          done = 1'b1;
        end else if (op == "#") begin
          // comment, skip to end of line
          c = 0;
          while (c != 10 && c != -1) begin
            c = $fgetc(fd);
          end
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h", f_addr, f_size, f_wdata, f_rdata, f_resp);
          if (n != 5) begin
            other_cnt++;
            done = 1'b1;
            $display("stimulus line for op %c has missing fields", op);
          end else if (op == "W" || op == "R") begin
            xfer_cnt++;
            run_transfer(op == "W", f_addr, f_size[2:0], f_wdata, f_rdata, f_resp[0]);
          end else if (op == "I") begin
            check_idle();
          end else begin
            other_cnt++;
            $display("unknown op %c in the stimulus file", op);
          end
        end
      end
      $fclose(fd);
      if (xfer_cnt == 0) begin
        other_cnt++;
        $display("no transfers were read from the stimulus file");
      end
    end

    err_cnt = mismatch_cnt + timeout_cnt + other_cnt;
    $display("transfers %0d, errors %0d: mismatches %0d, timeouts %0d, other %0d",
             xfer_cnt, err_cnt, mismatch_cnt, timeout_cnt, other_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
